//--- Bender.yml
package:
  name: eeprom_subsys

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/eeprom_pkg.sv
      - source/eeprom_bus_if.sv
      - source/eeprom_cmd_port.sv
      - source/eeprom_arbiter.sv
      - source/i2c_eeprom_master.sv
      - source/eeprom_subsys_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/i2c_eeprom_model.sv
      - sim/eeprom_subsys_sva.sv
      - sim/tb_eeprom_subsys.sv

//--- sim.f
+incdir+source
source/eeprom_pkg.sv
source/eeprom_bus_if.sv
source/eeprom_cmd_port.sv
source/eeprom_arbiter.sv
source/i2c_eeprom_master.sv
source/eeprom_subsys_top.sv
sim/i2c_eeprom_model.sv
sim/eeprom_subsys_sva.sv
sim/tb_eeprom_subsys.sv

//--- sim/eeprom_subsys_sva.sv
`include "eeprom_params.svh"

module eeprom_subsys_sva (
    input logic                    CLK,
    input logic                    RESET,
    input eeprom_pkg::link_state_e state,
    input logic                    scl,
    input logic                    sda_low,
    input logic                    done,
    input logic [3:0]              outstanding
);
    import eeprom_pkg::*;

    logic start_stop;

    assign start_stop = (state == L_START) || (state == L_RESTART) || (state == L_STOP);

    sda_steady_while_scl_high: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && (sda_low != $past(sda_low))) |-> $past(start_stop))
        else $error("sda moved while scl high outside start or stop");

    done_single_cycle: assert property (@(posedge CLK) disable iff (RESET)
        done |=> !done)
        else $error("done held for more than one cycle");

    outstanding_in_range: assert property (@(posedge CLK) disable iff (RESET)
        outstanding <= `EEPROM_CREDITS)
        else $error("port holds more operations than credits");

endmodule

bind i2c_eeprom_master eeprom_subsys_sva engine_sva (
    .CLK(CLK), .RESET(RESET), .state(state), .scl(scl), .sda_low(sda_low),
    .done(bus.done), .outstanding(4'd0)
);

bind eeprom_cmd_port eeprom_subsys_sva port_sva (
    .CLK(CLK), .RESET(RESET), .state(eeprom_pkg::L_IDLE), .scl(1'b1), .sda_low(1'b0),
    .done(1'b0), .outstanding(4'(outstanding))
);

//--- sim/i2c_eeprom_model.sv
`include "eeprom_params.svh"

module i2c_eeprom_model (
    input  logic scl,
    input  logic sda,
    input  logic force_nack,
    output logic sda_pull
);
    localparam int IDLE = 0, CTRL = 1, ADDR = 2, WDATA = 3, RDATA = 4;

    logic [`EEPROM_DATA_W-1:0]  mem [1 << `EEPROM_ADDR_W];
    logic [7:0]                 rx;
    logic [7:0]                 tx;
    logic [`EEPROM_ADDR_W-9:0]  hi;  // block bits from the control byte
    logic [`EEPROM_ADDR_W-1:0]  ptr;
    int                         st = IDLE;
    int                         nxt = IDLE;
    int                         cnt = 0;  // scl rising edges within the byte

    initial
        sda_pull = 1'b0;

    always @(negedge sda)
        if (scl === 1'b1)
        begin
            st = CTRL;  // start or repeated start
            cnt = 0;
            sda_pull = 1'b0;
        end

    always @(posedge sda)
        if (scl === 1'b1)
            st = IDLE;  // stop

    always @(posedge scl)
        if (st != IDLE)
        begin
            if (cnt < 8)
                rx = {rx[6:0], sda};
            cnt = cnt + 1;
        end

    always @(negedge scl)
        if (st != IDLE)
        begin
            if (cnt == 9)
            begin
                cnt = 0;
                st = nxt;
                sda_pull = 1'b0;
                if (st == RDATA)
                begin
                    tx = mem[ptr];
                    sda_pull = !tx[7];
                end
            end
            else if (st == RDATA)
            begin
                if (cnt == 8)
                begin
                    sda_pull = 1'b0;  // master ack slot, single byte only
                    nxt = IDLE;
                end
                else if (cnt > 0)
                begin
                    tx = tx << 1;
                    sda_pull = !tx[7];
                end
            end
            else if (cnt == 8)
            begin
                nxt = IDLE;
                sda_pull = 1'b0;
                if (!force_nack)
                    case (st)
                        CTRL:
                            if (rx[7:4] == `EEPROM_DEV_CODE)
                            begin
                                hi = rx[3:1];
                                nxt = rx[0] ? RDATA : ADDR;
                                sda_pull = 1'b1;
                            end
                        ADDR:
                        begin
                            ptr = {hi, rx};
                            nxt = WDATA;
                            sda_pull = 1'b1;
                        end
                        default:
                        begin
                            mem[ptr] = rx;
                            sda_pull = 1'b1;
                        end
                    endcase
            end
        end

endmodule

//--- sim/tb_eeprom_subsys.sv
`include "eeprom_params.svh"

module tb_eeprom_subsys;
    import eeprom_pkg::*;

    localparam int CREDITS = `EEPROM_CREDITS;
    localparam int WAIT_LIMIT = 5000;  // cycles
    localparam int MEM_SIZE = 1 << `EEPROM_ADDR_W;

    logic                      CLK;
    logic                      RESET;
    logic                      cmd_valid_0, cmd_valid_1, cmd_op_0, cmd_op_1;
    logic [`EEPROM_ADDR_W-1:0] cmd_addr_0, cmd_addr_1;
    logic [`EEPROM_DATA_W-1:0] cmd_wdata_0, cmd_wdata_1, rsp_rdata_0, rsp_rdata_1;
    logic                      rsp_valid_0, rsp_valid_1, rsp_nack_0, rsp_nack_1;
    logic                      credit_0, credit_1;
    logic                      scl, sda_low, sda_in, model_pull, force_nack;

    logic [`EEPROM_DATA_W-1:0] ref_mem [MEM_SIZE];
    eeprom_rsp_t               exp_q [2][$];
    int                        credits [2];
    int                        sent [2];
    int                        returned [2];
    int                        resp_order [$];
    integer                    seed;

    assign sda_in = !(sda_low || model_pull);  // wired-and

    eeprom_subsys_top uut (
        .CLK(CLK), .RESET(RESET),
        .cmd_valid_0(cmd_valid_0), .cmd_op_0(cmd_op_0), .cmd_addr_0(cmd_addr_0),
        .cmd_wdata_0(cmd_wdata_0), .rsp_valid_0(rsp_valid_0), .rsp_rdata_0(rsp_rdata_0),
        .rsp_nack_0(rsp_nack_0), .credit_0(credit_0),
        .cmd_valid_1(cmd_valid_1), .cmd_op_1(cmd_op_1), .cmd_addr_1(cmd_addr_1),
        .cmd_wdata_1(cmd_wdata_1), .rsp_valid_1(rsp_valid_1), .rsp_rdata_1(rsp_rdata_1),
        .rsp_nack_1(rsp_nack_1), .credit_1(credit_1),
        .scl(scl), .sda_low(sda_low), .sda_in(sda_in)
    );

    i2c_eeprom_model eeprom (
        .scl(scl), .sda(sda_in), .force_nack(force_nack), .sda_pull(model_pull)
    );

    initial
    begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_rsp(input string name, input eeprom_rsp_t got, input eeprom_rsp_t exp);
        if (got !== exp)
            stop_with_failure($sformatf("error %s: got %0h expected %0h", name, got, exp));
    endtask

    task automatic check_credit(input string name, input int got, input int exp);
        if (got != exp)
            stop_with_failure($sformatf("error %s: got %0h expected %0h", name, got, exp));
    endtask

    task automatic check_byte(input string name, input logic [`EEPROM_DATA_W-1:0] got,
                              input logic [`EEPROM_DATA_W-1:0] exp);
        if (got !== exp)
            stop_with_failure($sformatf("error %s: got %0h expected %0h", name, got, exp));
    endtask

    function automatic logic [`EEPROM_DATA_W-1:0] fill_pattern(input int a);
        return 8'(a ^ (a >> 3) ^ 'h5a);
    endfunction

    // expected response of one op and its effect on the reference array
    function automatic eeprom_rsp_t ref_op(input eeprom_cmd_t c, input logic nack);
        eeprom_rsp_t r;
        r.nack = nack;
        r.rdata = '0;
        if (!nack && c.op == OP_WRITE)
            ref_mem[c.addr] = c.wdata;
        else if (!nack)
            r.rdata = ref_mem[c.addr];
        return r;
    endfunction

    task automatic step;
        @(posedge CLK);
        #5;
    endtask

    task automatic send(input int p, input eeprom_op_e op,
                        input logic [`EEPROM_ADDR_W-1:0] addr,
                        input logic [`EEPROM_DATA_W-1:0] wdata);
        eeprom_cmd_t c;
        int          t;
        c = '{op: op, addr: addr, wdata: wdata};
        t = 0;
        while (credits[p] == 0)
        begin
            step();
            t++;
            if (t > WAIT_LIMIT)
                stop_with_failure($sformatf("port %0d never got a credit back", p));
        end
        credits[p]--;
        sent[p]++;
        exp_q[p].push_back(ref_op(c, force_nack));
        if (p == 0)
        begin
            cmd_valid_0 = 1'b1;
            cmd_op_0 = op;
            cmd_addr_0 = addr;
            cmd_wdata_0 = wdata;
        end
        else
        begin
            cmd_valid_1 = 1'b1;
            cmd_op_1 = op;
            cmd_addr_1 = addr;
            cmd_wdata_1 = wdata;
        end
        step();
        if (p == 0)
            cmd_valid_0 = 1'b0;
        else
            cmd_valid_1 = 1'b0;
    endtask

    task automatic wait_idle;
        int t;
        t = 0;
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0)
        begin
            step();
            t++;
            if (t > WAIT_LIMIT)
                stop_with_failure("responses still outstanding after the timeout");
        end
    endtask

    task automatic take_rsp(input int p, input eeprom_rsp_t got);
        if (exp_q[p].size() == 0)
            stop_with_failure($sformatf("port %0d answered with nothing outstanding", p));
        else
        begin
            check_rsp($sformatf("rsp_%0d", p), got, exp_q[p].pop_front());
            resp_order.push_back(p);
        end
    endtask

    task automatic collect_credit(input int p);
        credits[p]++;
        returned[p]++;
        if (credits[p] > CREDITS)
            stop_with_failure($sformatf("port %0d holds more credits than allowed", p));
    endtask

    // response and credit monitor
    always @(negedge CLK)
    begin
        if (RESET === 1'b0)
        begin
            check_credit("credit_0", int'(credit_0), int'(rsp_valid_0));
            check_credit("credit_1", int'(credit_1), int'(rsp_valid_1));
            if (rsp_valid_0)
                take_rsp(0, {rsp_rdata_0, rsp_nack_0});
            if (rsp_valid_1)
                take_rsp(1, {rsp_rdata_1, rsp_nack_1});
            if (credit_0)
                collect_credit(0);
            if (credit_1)
                collect_credit(1);
        end
    end

    initial
    begin
        int          p;
        logic [31:0] r;
        RESET = 1'b1;
        cmd_valid_0 = 1'b0;
        cmd_valid_1 = 1'b0;
        cmd_op_0 = 1'b0;
        cmd_op_1 = 1'b0;
        cmd_addr_0 = '0;
        cmd_addr_1 = '0;
        cmd_wdata_0 = '0;
        cmd_wdata_1 = '0;
        force_nack = 1'b0;
        seed = 32'h2517;
        for (int q = 0; q < 2; q++)
        begin
            credits[q] = CREDITS;
            sent[q] = 0;
            returned[q] = 0;
        end
        for (int i = 0; i < MEM_SIZE; i++)
        begin
            ref_mem[i] = fill_pattern(i);
            eeprom.mem[i] = fill_pattern(i);
        end
        repeat (10) @(posedge CLK);
        #5;
        RESET = 1'b0;
        repeat (20) step();
        if (scl !== 1'b1 || sda_low !== 1'b0)
            stop_with_failure("scl and sda are not idle after reset");

        send(0, OP_WRITE, 11'h123, 8'hc3);
        send(0, OP_READ, 11'h123, 8'h00);
        wait_idle();
        check_byte("mem[123]", eeprom.mem[11'h123], ref_mem[11'h123]);

        // port 0 keeps to even addresses and port 1 to odd ones
        for (int i = 0; i < 40; i++)
        begin
            p = $random(seed) & 1;
            r = $random(seed);
            send(p, eeprom_op_e'(r[0]), {r[12:3], 1'(p)}, r[20:13]);
        end
        wait_idle();

        resp_order.delete();
        for (int i = 0; i < 2; i++)
            fork
                send(0, OP_WRITE, 11'h200 + 11'(2 * i), 8'h90 + 8'(i));
                send(1, OP_READ, 11'h201 + 11'(2 * i), 8'h00);
            join
        wait_idle();
        if (resp_order.size() != 4)
            stop_with_failure("wrong number of responses from the paired ports");
        for (int i = 1; i < 4; i++)
            if (resp_order[i] == resp_order[i - 1])
                stop_with_failure("responses did not alternate between the ports");

        force_nack = 1'b1;
        send(0, OP_WRITE, 11'h0aa, 8'h3c);
        send(1, OP_READ, 11'h0ab, 8'h00);
        wait_idle();
        force_nack = 1'b0;
        send(0, OP_READ, 11'h0aa, 8'h00);  // refused write left the old byte
        wait_idle();

        for (int i = 0; i < MEM_SIZE; i++)
            check_byte($sformatf("mem[%0h]", i), eeprom.mem[i], ref_mem[i]);
        for (int q = 0; q < 2; q++)
        begin
            check_credit($sformatf("returned_%0d", q), returned[q], sent[q]);
            check_credit($sformatf("credits_%0d", q), credits[q], CREDITS);
        end
        $display("test passed");
        $finish;
    end

endmodule

//--- source/eeprom_arbiter.sv
`include "eeprom_params.svh"

module eeprom_arbiter (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    head_valid_0,
    input  logic                    head_valid_1,
    input  eeprom_pkg::eeprom_cmd_t head_cmd_0,
    input  eeprom_pkg::eeprom_cmd_t head_cmd_1,
    output logic                    pop_0,
    output logic                    pop_1,
    output logic                    rsp_strobe_0,
    output logic                    rsp_strobe_1,
    output eeprom_pkg::eeprom_rsp_t rsp,
    eeprom_bus_if.arb               bus
);
    import eeprom_pkg::*;

    logic pick;  // port chosen this cycle

    // bus.src doubles as the last grant for round robin
    always_comb
    begin
        if (head_valid_0 && head_valid_1)
            pick = ~bus.src;
        else
            pick = head_valid_1;
    end

    assign bus.req = !bus.busy && (head_valid_0 || head_valid_1);
    assign bus.cmd = pick ? head_cmd_1 : head_cmd_0;
    assign pop_0 = bus.req && !pick;
    assign pop_1 = bus.req && pick;

    // done goes back to the port that issued the op
    assign rsp_strobe_0 = bus.done && !bus.src;
    assign rsp_strobe_1 = bus.done && bus.src;
    assign rsp = bus.rsp;

    always_ff @(posedge CLK)
    begin
        if (RESET)
            bus.src <= 1'b1;  // port 0 first
        else if (bus.req)
            bus.src <= pick;
    end

endmodule

//--- source/eeprom_bus_if.sv
`include "eeprom_params.svh"

interface eeprom_bus_if;
    import eeprom_pkg::*;

    logic        req;
    eeprom_cmd_t cmd;
    logic        src;  // port owning the op in flight
    logic        busy;
    logic        done;  // one cycle, rsp valid
    eeprom_rsp_t rsp;

    modport arb (
        output req, cmd, src,
        input  busy, done, rsp
    );

    modport eng (
        input  req, cmd,
        output busy, done, rsp
    );

endinterface

//--- source/eeprom_cmd_port.sv
`include "eeprom_params.svh"

module eeprom_cmd_port (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    cmd_valid,
    input  eeprom_pkg::eeprom_cmd_t cmd,
    output logic                    head_valid,
    output eeprom_pkg::eeprom_cmd_t head_cmd,
    input  logic                    pop,
    input  logic                    rsp_strobe,
    input  eeprom_pkg::eeprom_rsp_t rsp_in,
    output logic                    rsp_valid,
    output eeprom_pkg::eeprom_rsp_t rsp,
    output logic                    credit
);
    import eeprom_pkg::*;

    localparam int DEPTH = `EEPROM_CREDITS;
    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    eeprom_cmd_t   fifo [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic [CW-1:0] outstanding;  // accepted but not yet answered

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
        return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign head_valid = (count != '0);
    assign head_cmd = fifo[rd_ptr];
    assign credit = rsp_valid;  // credit goes back with the response

    // no full check, host credits keep the queue from overflowing
    always_ff @(posedge CLK)
    begin
        if (cmd_valid)
            fifo[wr_ptr] <= cmd;
        if (rsp_strobe)
            rsp <= rsp_in;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            outstanding <= '0;
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= rsp_strobe;
            if (cmd_valid)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            count <= count + CW'(cmd_valid) - CW'(pop);
            outstanding <= outstanding + CW'(cmd_valid) - CW'(rsp_valid);
        end
    end

endmodule

//--- source/eeprom_params.svh
`ifndef EEPROM_PARAMS_SVH
`define EEPROM_PARAMS_SVH

// byte address and data widths
`define EEPROM_ADDR_W 11
`define EEPROM_DATA_W 8

`define EEPROM_CREDITS 2 // also the queue depth per port

`define EEPROM_DEV_CODE 4'b1010
`define EEPROM_QTR_CLKS 2 // clk cycles per quarter scl bit

`endif

//--- source/eeprom_pkg.sv
`include "eeprom_params.svh"

package eeprom_pkg;

    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } eeprom_op_e;

    typedef struct packed {
        eeprom_op_e                op;
        logic [`EEPROM_ADDR_W-1:0] addr;
        logic [`EEPROM_DATA_W-1:0] wdata;
    } eeprom_cmd_t;

    typedef struct packed {
        logic [`EEPROM_DATA_W-1:0] rdata;
        logic                      nack;
    } eeprom_rsp_t;

    typedef enum {
        L_IDLE, L_START, L_CTRL_WR, L_ADDR, L_DATA_WR,
        L_RESTART, L_CTRL_RD, L_DATA_RD, L_MACK, L_STOP
    } link_state_e;

endpackage

//--- source/eeprom_subsys_top.sv
`include "eeprom_params.svh"

module eeprom_subsys_top (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      cmd_valid_0,
    input  logic                      cmd_op_0,
    input  logic [`EEPROM_ADDR_W-1:0] cmd_addr_0,
    input  logic [`EEPROM_DATA_W-1:0] cmd_wdata_0,
    output logic                      rsp_valid_0,
    output logic [`EEPROM_DATA_W-1:0] rsp_rdata_0,
    output logic                      rsp_nack_0,
    output logic                      credit_0,
    input  logic                      cmd_valid_1,
    input  logic                      cmd_op_1,
    input  logic [`EEPROM_ADDR_W-1:0] cmd_addr_1,
    input  logic [`EEPROM_DATA_W-1:0] cmd_wdata_1,
    output logic                      rsp_valid_1,
    output logic [`EEPROM_DATA_W-1:0] rsp_rdata_1,
    output logic                      rsp_nack_1,
    output logic                      credit_1,
    output logic                      scl,
    output logic                      sda_low,
    input  logic                      sda_in
);
    import eeprom_pkg::*;

    eeprom_cmd_t cmd_0, cmd_1;
    eeprom_cmd_t head_cmd_0, head_cmd_1;
    eeprom_rsp_t rsp_0, rsp_1, arb_rsp;
    logic        head_valid_0, head_valid_1;
    logic        pop_0, pop_1;
    logic        rsp_strobe_0, rsp_strobe_1;

    assign cmd_0 = '{op: eeprom_op_e'(cmd_op_0), addr: cmd_addr_0, wdata: cmd_wdata_0};
    assign cmd_1 = '{op: eeprom_op_e'(cmd_op_1), addr: cmd_addr_1, wdata: cmd_wdata_1};
    assign rsp_rdata_0 = rsp_0.rdata;
    assign rsp_nack_0 = rsp_0.nack;
    assign rsp_rdata_1 = rsp_1.rdata;
    assign rsp_nack_1 = rsp_1.nack;

    eeprom_bus_if bus_if ();

    eeprom_cmd_port port_0 (
        .CLK(CLK), .RESET(RESET), .cmd_valid(cmd_valid_0), .cmd(cmd_0),
        .head_valid(head_valid_0), .head_cmd(head_cmd_0), .pop(pop_0),
        .rsp_strobe(rsp_strobe_0), .rsp_in(arb_rsp), .rsp_valid(rsp_valid_0),
        .rsp(rsp_0), .credit(credit_0)
    );

    eeprom_cmd_port port_1 (
        .CLK(CLK), .RESET(RESET), .cmd_valid(cmd_valid_1), .cmd(cmd_1),
        .head_valid(head_valid_1), .head_cmd(head_cmd_1), .pop(pop_1),
        .rsp_strobe(rsp_strobe_1), .rsp_in(arb_rsp), .rsp_valid(rsp_valid_1),
        .rsp(rsp_1), .credit(credit_1)
    );

    eeprom_arbiter arb (
        .CLK(CLK), .RESET(RESET),
        .head_valid_0(head_valid_0), .head_valid_1(head_valid_1),
        .head_cmd_0(head_cmd_0), .head_cmd_1(head_cmd_1),
        .pop_0(pop_0), .pop_1(pop_1),
        .rsp_strobe_0(rsp_strobe_0), .rsp_strobe_1(rsp_strobe_1),
        .rsp(arb_rsp), .bus(bus_if.arb)
    );

    i2c_eeprom_master engine (
        .CLK(CLK), .RESET(RESET), .bus(bus_if.eng),
        .scl(scl), .sda_low(sda_low), .sda_in(sda_in)
    );

endmodule

//--- source/i2c_eeprom_master.sv
`include "eeprom_params.svh"

module i2c_eeprom_master (
    input  logic      CLK,
    input  logic      RESET,
    eeprom_bus_if.eng bus,
    output logic      scl,
    output logic      sda_low,
    input  logic      sda_in
);
    import eeprom_pkg::*;

    localparam int QW = (`EEPROM_QTR_CLKS > 1) ? $clog2(`EEPROM_QTR_CLKS) : 1;
    localparam int NB = `EEPROM_DATA_W;

    link_state_e             state;
    eeprom_cmd_t             cmd_q;
    eeprom_rsp_t             rsp_q;
    logic [QW-1:0]           qcnt;
    logic [1:0]              phase;  // scl low in 0,1 and high in 2,3
    logic [3:0]              bitcnt;
    logic [NB-1:0]           sh;
    logic                    tick;
    logic                    tx_byte;

    assign tick = (qcnt == QW'(`EEPROM_QTR_CLKS - 1));
    assign tx_byte = (state == L_CTRL_WR) || (state == L_ADDR) ||
                     (state == L_DATA_WR) || (state == L_CTRL_RD);
    assign bus.rsp = rsp_q;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= L_IDLE;
            qcnt <= '0;
            phase <= '0;
            bitcnt <= '0;
            scl <= 1'b1;
            sda_low <= 1'b0;
            bus.busy <= 1'b0;
            bus.done <= 1'b0;
        end
        else
        begin
            bus.done <= 1'b0;
            if (state == L_IDLE)
            begin
                if (bus.req)
                begin
                    cmd_q <= bus.cmd;
                    rsp_q <= '0;  // rdata stays zero unless the read completes
                    state <= L_START;
                    bus.busy <= 1'b1;
                    scl <= 1'b0;
                end
            end
            else if (!tick)
                qcnt <= qcnt + 1'b1;
            else
            begin
                qcnt <= '0;
                phase <= phase + 2'd1;
                case (phase)
                    2'd0:
                    begin
                        // middle of scl low, data may move
                        case (state)
                            L_STOP:
                                sda_low <= 1'b1;
                            L_CTRL_WR, L_ADDR, L_DATA_WR, L_CTRL_RD:
                                sda_low <= (bitcnt != 4'(NB)) && !sh[NB-1];
                            default:
                                sda_low <= 1'b0;
                        endcase
                    end
                    2'd1:
                        scl <= 1'b1;
                    2'd2:
                    begin
                        // middle of scl high
                        if (state == L_START || state == L_RESTART)
                            sda_low <= 1'b1;
                        else if (state == L_STOP)
                            sda_low <= 1'b0;
                        else if (state == L_DATA_RD)
                            sh <= {sh[NB-2:0], sda_in};
                        else if (tx_byte && bitcnt == 4'(NB) && sda_in)
                            rsp_q.nack <= 1'b1;  // no ack from slave
                    end
                    default:
                    begin
                        if (state != L_STOP)
                            scl <= 1'b0;
                        bitcnt <= bitcnt + 4'd1;
                        case (state)
                            L_START:
                            begin
                                state <= L_CTRL_WR;
                                sh <= {`EEPROM_DEV_CODE, cmd_q.addr[`EEPROM_ADDR_W-1:8], 1'b0};
                                bitcnt <= '0;
                            end
                            L_CTRL_WR, L_ADDR, L_DATA_WR, L_CTRL_RD:
                            begin
                                if (bitcnt != 4'(NB))
                                    sh <= {sh[NB-2:0], 1'b0};
                                else
                                begin
                                    bitcnt <= '0;
                                    if (rsp_q.nack || state == L_DATA_WR)
                                        state <= L_STOP;
                                    else if (state == L_CTRL_WR)
                                    begin
                                        state <= L_ADDR;
                                        sh <= cmd_q.addr[7:0];
                                    end
                                    else if (state == L_CTRL_RD)
                                        state <= L_DATA_RD;
                                    else if (cmd_q.op == OP_READ)
                                        state <= L_RESTART;
                                    else
                                    begin
                                        state <= L_DATA_WR;
                                        sh <= cmd_q.wdata;
                                    end
                                end
                            end
                            L_RESTART:
                            begin
                                state <= L_CTRL_RD;
                                sh <= {`EEPROM_DEV_CODE, cmd_q.addr[`EEPROM_ADDR_W-1:8], 1'b1};
                                bitcnt <= '0;
                            end
                            L_DATA_RD:
                                if (bitcnt == 4'(NB - 1))
                                    state <= L_MACK;
                            L_MACK:
                            begin
                                state <= L_STOP;  // master nack, single byte read
                                rsp_q.rdata <= sh;
                            end
                            L_STOP:
                            begin
                                state <= L_IDLE;
                                bus.busy <= 1'b0;
                                bus.done <= 1'b1;
                            end
                            default:
                                state <= L_IDLE;
                        endcase
                    end
                endcase
            end
        end
    end

endmodule
